// File: hw/core_pkg.sv
package core_pkg;

    // ============================================================
    // Widths and basic types
    // ============================================================
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [31:0]           instr_t;

    // Major opcodes
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_branch = 7'b1100011;

    // funct3 codes, ALU group
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_srl = 3'b101;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;
    // funct3 codes, branch group
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;

    localparam word_t pc_step  = 32'd4;
    localparam word_t reset_pc = 32'h0000_0000;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_xor,
        alu_srl,
        alu_or,
        alu_and,
        alu_pass_b  // LUI
    } alu_op_e;

    // ============================================================
    // Stage payloads
    // ============================================================
    typedef struct packed {
        word_t  pc;
        instr_t instr;
    } if_id_t;

    typedef struct packed {
        word_t     pc;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        alu_op_e   alu_op;
        logic      alu_src_imm;
        logic      reg_write;
        logic      is_branch;
        logic      branch_ne;
    } id_ex_t;

    typedef struct packed {
        word_t     result;
        reg_addr_t rd;
        logic      reg_write;
    } ex_wb_t;

endpackage

// File: hw/stage_reg.sv
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hold,
    input  logic     flush,
    input  payload_t d,
    input  logic     d_valid,
    output payload_t q,
    output logic     q_valid
);

    // Valid bit, hold wins over flush
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_valid <= 1'b0;
        end else if (!hold) begin
            q_valid <= flush ? 1'b0 : d_valid;
        end
    end

    // Payload is don't-care while q_valid is low
    always_ff @(posedge clk) begin
        if (!hold) begin
            q <= d;
        end
    end

endmodule

// File: hw/fetch_unit.sv
module fetch_unit
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  hold,
    input  logic  branch_taken,
    input  word_t branch_target,
    output word_t pc
);

    word_t pc_next;

    always_comb begin
        if (hold) begin
            pc_next = pc;               // Fetch not granted
        end else if (branch_taken) begin
            pc_next = branch_target;    // Redirect from execute
        end else begin
            pc_next = pc + pc_step;     // Sequential, static not-taken
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

// File: hw/decode_unit.sv
module decode_unit
    import core_pkg::*;
(
    input  if_id_t    if_id,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output id_ex_t    id_ex
);

    instr_t    instr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_addr_t rd;
    word_t     imm_i;
    word_t     imm_u;
    word_t     imm_b;
    alu_op_e   arith_op;
    logic      arith_known;

    assign instr    = if_id.instr;
    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign rd       = instr[11:7];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    // Immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    // Shared funct3 decode for OP and OP-IMM
    always_comb begin
        arith_known = 1'b1;
        case (funct3)
            f3_add:  arith_op = (opcode == opc_op && instr[30]) ? alu_sub : alu_add;
            f3_sll:  arith_op = alu_sll;
            f3_slt:  arith_op = alu_slt;
            f3_xor:  arith_op = alu_xor;
            f3_srl:  arith_op = alu_srl;
            f3_or:   arith_op = alu_or;
            f3_and:  arith_op = alu_and;
            default: begin
                arith_op    = alu_add;
                arith_known = 1'b0;     // SLTU and friends
            end
        endcase
    end

    always_comb begin
        id_ex.pc          = if_id.pc;
        id_ex.rs1_data    = rs1_data;
        id_ex.rs2_data    = rs2_data;
        id_ex.rs1         = rs1_addr;
        id_ex.rs2         = rs2_addr;
        id_ex.rd          = rd;
        id_ex.imm         = imm_i;
        id_ex.alu_op      = alu_add;
        id_ex.alu_src_imm = 1'b0;
        id_ex.reg_write   = 1'b0;     // Unknown opcode is a no-op
        id_ex.is_branch   = 1'b0;
        id_ex.branch_ne   = 1'b0;

        case (opcode)
            opc_op: begin
                id_ex.alu_op    = arith_op;
                id_ex.reg_write = arith_known;
            end
            opc_op_imm: begin
                id_ex.alu_op      = arith_op;
                id_ex.alu_src_imm = 1'b1;
                id_ex.reg_write   = arith_known;
            end
            opc_lui: begin
                id_ex.imm         = imm_u;
                id_ex.alu_op      = alu_pass_b;
                id_ex.alu_src_imm = 1'b1;
                id_ex.reg_write   = 1'b1;
            end
            opc_branch: begin
                id_ex.imm       = imm_b;
                id_ex.is_branch = (funct3 == f3_beq) || (funct3 == f3_bne);
                id_ex.branch_ne = (funct3 == f3_bne);
            end
            default: ;
        endcase

        // x0 writes dropped here once for the whole pipe
        if (rd == '0) begin
            id_ex.reg_write = 1'b0;
        end
    end

endmodule

// File: hw/regfile.sv
module regfile
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      we,
    input  reg_addr_t rd_addr,
    input  word_t     wdata,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data
);

    word_t regs [1:31];   // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != '0) begin
            regs[rd_addr] <= wdata;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    always_comb begin
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end else if (we && rd_addr == rs1_addr) begin
            rs1_data = wdata;
        end else begin
            rs1_data = regs[rs1_addr];
        end

        if (rs2_addr == '0) begin
            rs2_data = '0;
        end else if (we && rd_addr == rs2_addr) begin
            rs2_data = wdata;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

// File: hw/execute_unit.sv
module execute_unit
    import core_pkg::*;
(
    input  id_ex_t id_ex,
    input  logic   id_ex_valid,
    input  ex_wb_t wb,
    input  logic   wb_valid,
    output ex_wb_t ex_wb,
    output logic   branch_taken,
    output word_t  branch_target
);

    logic       fwd_a;
    logic       fwd_b;
    word_t      op_a;
    word_t      op_b_reg;
    word_t      alu_b;
    logic [4:0] shamt;
    word_t      alu_result;
    logic       ops_equal;

    // ============================================================
    // Forwarding from write-back
    // ============================================================
    // rd of x0 never carries reg_write, so no zero check here
    assign fwd_a = wb_valid && wb.reg_write && (wb.rd == id_ex.rs1);
    assign fwd_b = wb_valid && wb.reg_write && (wb.rd == id_ex.rs2);

    assign op_a     = fwd_a ? wb.result : id_ex.rs1_data;
    assign op_b_reg = fwd_b ? wb.result : id_ex.rs2_data;
    assign alu_b    = id_ex.alu_src_imm ? id_ex.imm : op_b_reg;
    assign shamt    = alu_b[4:0];

    // ============================================================
    // ALU
    // ============================================================
    always_comb begin
        case (id_ex.alu_op)
            alu_add:    alu_result = op_a + alu_b;
            alu_sub:    alu_result = op_a - alu_b;
            alu_sll:    alu_result = op_a << shamt;
            alu_slt:    alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            alu_xor:    alu_result = op_a ^ alu_b;
            alu_srl:    alu_result = op_a >> shamt;
            alu_or:     alu_result = op_a | alu_b;
            alu_and:    alu_result = op_a & alu_b;
            alu_pass_b: alu_result = alu_b;
            default:    alu_result = '0;
        endcase
    end

    assign ex_wb.result    = alu_result;
    assign ex_wb.rd        = id_ex.rd;
    assign ex_wb.reg_write = id_ex.reg_write;

    // ============================================================
    // Branch resolution
    // ============================================================
    assign ops_equal     = (op_a == op_b_reg);
    assign branch_taken  = id_ex_valid && id_ex.is_branch && (ops_equal ^ id_ex.branch_ne);
    assign branch_target = id_ex.pc + id_ex.imm;

endmodule

// File: hw/core.sv
module core
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  instr_t    instr,
    input  logic      instr_gnt,
    output word_t     pc_addr,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output word_t     wb_data
);

    logic      stall;
    logic      branch_taken;
    word_t     branch_target;
    if_id_t    if_id_d;
    if_id_t    if_id_q;
    logic      if_id_valid;
    id_ex_t    id_ex_d;
    id_ex_t    id_ex_q;
    logic      id_ex_valid;
    ex_wb_t    ex_wb_d;
    ex_wb_t    ex_wb_q;
    logic      ex_wb_valid;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    assign stall = !instr_gnt;   // Missing grant freezes every stage

    // ============================================================
    // Fetch
    // ============================================================
    fetch_unit fetch0 (
        .clk(clk), .rst_n(rst_n), .hold(stall),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .pc(pc_addr)
    );

    assign if_id_d.pc    = pc_addr;
    assign if_id_d.instr = instr;

    stage_reg #(.payload_t(if_id_t)) if_id_reg (
        .clk(clk), .rst_n(rst_n), .hold(stall), .flush(branch_taken),
        .d(if_id_d), .d_valid(1'b1), .q(if_id_q), .q_valid(if_id_valid)
    );

    // ============================================================
    // Decode
    // ============================================================
    decode_unit decode0 (
        .if_id(if_id_q), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .id_ex(id_ex_d)
    );

    regfile regfile0 (
        .clk(clk), .rst_n(rst_n),
        .we(wb_valid), .rd_addr(ex_wb_q.rd), .wdata(ex_wb_q.result),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    stage_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .clk(clk), .rst_n(rst_n), .hold(stall), .flush(branch_taken),
        .d(id_ex_d), .d_valid(if_id_valid), .q(id_ex_q), .q_valid(id_ex_valid)
    );

    // ============================================================
    // Execute and write-back
    // ============================================================
    execute_unit execute0 (
        .id_ex(id_ex_q), .id_ex_valid(id_ex_valid),
        .wb(ex_wb_q), .wb_valid(ex_wb_valid),
        .ex_wb(ex_wb_d), .branch_taken(branch_taken), .branch_target(branch_target)
    );

    // Branch itself moves on, it carries no register write
    stage_reg #(.payload_t(ex_wb_t)) ex_wb_reg (
        .clk(clk), .rst_n(rst_n), .hold(stall), .flush(1'b0),
        .d(ex_wb_d), .d_valid(id_ex_valid), .q(ex_wb_q), .q_valid(ex_wb_valid)
    );

    assign wb_valid = ex_wb_valid && ex_wb_q.reg_write;   // Also the regfile write enable
    assign wb_rd    = ex_wb_q.rd;
    assign wb_data  = ex_wb_q.result;

endmodule

// File: testbench/core_checker.sv
module core_checker
    import core_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      instr_gnt,
    input word_t     pc_addr,
    input logic      wb_valid,
    input reg_addr_t wb_rd
);

    // Fetch addresses stay on word boundaries
    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc_addr[1:0] == 2'b00)
        else $error("pc_addr not word-aligned: %h", pc_addr);

    // No grant at an edge means the PC did not move
    pc_held: assert property (@(posedge clk) disable iff (!rst_n)
        !instr_gnt |=> $stable(pc_addr))
        else $error("pc_addr changed after a cycle without grant");

    wb_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> wb_rd != '0)
        else $error("wb_valid high with wb_rd of x0");

    wb_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(wb_valid))
        else $error("wb_valid is unknown");

endmodule

// File: testbench/core_tb.sv
module core_tb
    import core_pkg::*;
();

    localparam int rom_depth        = 64;
    localparam int gnt_pct          = 75;
    localparam int lcg_seed         = 89731;
    localparam int num_writes       = 400;
    localparam int cycles_per_write = 20;
    localparam int timeout_cycles   = num_writes * cycles_per_write;
    localparam int model_step_limit = num_writes * 200;

    // Instruction kinds of the generated program
    localparam int kind_nop = 0;
    localparam int kind_r   = 1;
    localparam int kind_i   = 2;
    localparam int kind_lui = 3;
    localparam int kind_br  = 4;

    localparam int op_add = 0;
    localparam int op_sub = 1;
    localparam int op_sll = 2;
    localparam int op_slt = 3;
    localparam int op_xor = 4;
    localparam int op_srl = 5;
    localparam int op_or  = 6;

    logic      clk;
    logic      rst_n;
    instr_t    instr;
    logic      instr_gnt;
    word_t     pc_addr;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;

    logic [31:0] rng_state;
    instr_t      rom [0:rom_depth-1];
    int          kind_m [0:rom_depth-1];
    int          op_m [0:rom_depth-1];     // ALU op or 1 for BNE
    reg_addr_t   rd_m [0:rom_depth-1];
    reg_addr_t   rs1_m [0:rom_depth-1];
    reg_addr_t   rs2_m [0:rom_depth-1];
    word_t       imm_m [0:rom_depth-1];
    logic        writes_reg [0:rom_depth-1];
    reg_addr_t   exp_rd [0:num_writes-1];
    word_t       exp_data [0:num_writes-1];
    int          n_got;

    core dut0 (
        .clk(clk), .rst_n(rst_n), .instr(instr), .instr_gnt(instr_gnt),
        .pc_addr(pc_addr), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    bind core core_checker checker0 (
        .clk(clk), .rst_n(rst_n), .instr_gnt(instr_gnt), .pc_addr(pc_addr),
        .wb_valid(wb_valid), .wb_rd(wb_rd)
    );

    assign instr = rom[pc_addr[7:2]];   // Program wraps every 64 words

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ============================================================
    // Random numbers and reference model
    // ============================================================
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int draw_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[31:16]) % n;      // Upper bits are the better ones
    endfunction

    function automatic logic [2:0] op_funct3(input int op);
        case (op)
            op_add, op_sub: return f3_add;
            op_sll:         return f3_sll;
            op_slt:         return f3_slt;
            op_xor:         return f3_xor;
            op_srl:         return f3_srl;
            op_or:          return f3_or;
            default:        return f3_and;
        endcase
    endfunction

    function automatic word_t alu_model(input int op, input word_t a, input word_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_sll:  return a << b[4:0];
            op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_xor:  return a ^ b;
            op_srl:  return a >> b[4:0];
            op_or:   return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic fill_rom();
        int          sel;
        int          k;
        int          t;
        int          tries;
        logic [31:0] r;
        logic [11:0] imm12;
        logic [12:0] off;
        for (int i = 0; i < rom_depth; i++) begin
            sel = (i == 0) ? 50 : draw_below(100);   // Word 0 must write
            rd_m[i]  = (i == 0) ? reg_addr_t'(1 + draw_below(7)) : reg_addr_t'(draw_below(8));
            rs1_m[i] = reg_addr_t'(draw_below(8));   // Few registers give many hazards
            rs2_m[i] = reg_addr_t'(draw_below(8));
            r = next_rand();
            if (sel < 5) begin
                kind_m[i] = kind_nop;
                rom[i] = {r[31:7], r[0] ? 7'b0000011 : 7'b1101111};  // Load or JAL
            end else if (sel < 35) begin
                kind_m[i] = kind_r;
                op_m[i] = draw_below(8);
                rom[i] = {(op_m[i] == op_sub) ? 7'b0100000 : 7'b0000000, rs2_m[i], rs1_m[i],
                          op_funct3(op_m[i]), rd_m[i], opc_op};
            end else if (sel < 70) begin
                kind_m[i] = kind_i;
                op_m[i] = draw_below(8);
                if (op_m[i] == op_sub) op_m[i] = op_add;   // No SUBI
                imm12 = r[31:20];
                if (op_m[i] == op_sll || op_m[i] == op_srl) imm12 = {7'b0, r[24:20]};
                imm_m[i] = {{20{imm12[11]}}, imm12};
                rom[i] = {imm12, rs1_m[i], op_funct3(op_m[i]), rd_m[i], opc_op_imm};
            end else if (sel < 80) begin
                kind_m[i] = kind_lui;
                imm_m[i] = {r[31:12], 12'b0};
                rom[i] = {r[31:12], rd_m[i], opc_lui};
            end else begin
                kind_m[i] = kind_br;
                op_m[i] = draw_below(2);
                // A wrap or backward jump lands on a writing word, so no loop is write-free
                k = 0;
                tries = 0;
                while (k == 0) begin
                    k = draw_below(65) - 32;
                    t = (i + k) & (rom_depth - 1);
                    if (k != 0 && t < i && !writes_reg[t]) k = 0;
                    tries++;
                    if (k == 0 && tries >= 16) k = 1;
                end
                off = 13'(k * 4);
                imm_m[i] = word_t'(k * 4);
                rom[i] = {off[12], off[10:5], rs2_m[i], rs1_m[i], op_m[i] == 1 ? f3_bne : f3_beq,
                          off[4:1], off[11], opc_branch};
            end
            writes_reg[i] = (kind_m[i] == kind_r || kind_m[i] == kind_i ||
                             kind_m[i] == kind_lui) && rd_m[i] != '0;
        end
    endtask

    task automatic build_expected();
        word_t regs_m [0:31];
        word_t pc;
        word_t res;
        int    idx;
        int    steps;
        int    n_exp;
        logic  taken;
        for (int i = 0; i < 32; i++) regs_m[i] = '0;
        pc = reset_pc;
        steps = 0;
        n_exp = 0;
        while (n_exp < num_writes) begin
            if (steps > model_step_limit) begin
                $display("Reference model made too few writes in %0d steps", steps);
                end_with_failure();
            end
            idx = int'(pc[7:2]);
            res = '0;
            case (kind_m[idx])
                kind_r:   res = alu_model(op_m[idx], regs_m[rs1_m[idx]], regs_m[rs2_m[idx]]);
                kind_i:   res = alu_model(op_m[idx], regs_m[rs1_m[idx]], imm_m[idx]);
                kind_lui: res = imm_m[idx];
                default:  ;
            endcase
            if (writes_reg[idx]) begin
                regs_m[rd_m[idx]] = res;
                exp_rd[n_exp] = rd_m[idx];
                exp_data[n_exp] = res;
                n_exp++;
            end
            taken = (kind_m[idx] == kind_br) &&
                    ((regs_m[rs1_m[idx]] == regs_m[rs2_m[idx]]) ^ (op_m[idx] == 1));
            pc = taken ? pc + imm_m[idx] : pc + pc_step;
            steps++;
        end
    endtask

    // ============================================================
    // Compare tasks
    // ============================================================
    task automatic end_with_failure();
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_pc(input word_t act, input word_t exp, input string what);
        if (act !== exp) begin
            $display("FAIL at %0t: %s expected %h got %h", $time, what, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_rd(input reg_addr_t act, input reg_addr_t exp, input string what);
        if (act !== exp) begin
            $display("FAIL at %0t: %s expected x%0d got x%0d", $time, what, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_data(input word_t act, input word_t exp, input string what);
        if (act !== exp) begin
            $display("FAIL at %0t: %s expected %h got %h", $time, what, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_valid(input logic act, input logic exp, input string what);
        if (act !== exp) begin
            $display("FAIL at %0t: %s expected %b got %b", $time, what, exp, act);
            end_with_failure();
        end
    endtask

    // ============================================================
    // Stimulus and monitor
    // ============================================================
    initial begin
        rst_n = 1'b0;
        instr_gnt = 1'b0;
        rng_state = lcg_seed;
        fill_rom();
        build_expected();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_pc(pc_addr, reset_pc, "pc_addr after reset");
        check_valid(wb_valid, 1'b0, "wb_valid after reset");
        forever begin
            instr_gnt = (draw_below(100) < gnt_pct);
            @(posedge clk);
            #1;
        end
    end

    // Sample mid-cycle and count a write only when the next edge has grant
    initial begin
        int    cycles;
        logic  prev_gnt;
        word_t prev_pc;
        cycles = 0;
        n_got = 0;
        prev_gnt = 1'b1;
        prev_pc = reset_pc;
        @(posedge rst_n);
        while (n_got < num_writes) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("Timeout after %0d cycles with %0d of %0d writes seen",
                         timeout_cycles, n_got, num_writes);
                end_with_failure();
            end
            if (!prev_gnt) check_pc(pc_addr, prev_pc, "pc_addr without grant");
            if (instr_gnt && wb_valid) begin
                check_rd(wb_rd, exp_rd[n_got], "wb_rd");
                check_data(wb_data, exp_data[n_got], "wb_data");
                n_got++;
            end
            prev_gnt = instr_gnt;
            prev_pc = pc_addr;
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: src.f
hw/core_pkg.sv
hw/stage_reg.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/regfile.sv
hw/execute_unit.sv
hw/core.sv
testbench/core_checker.sv
testbench/core_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module core_tb -o core_tb_sim

./obj_dir/core_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
    exit 0
fi
exit 1
